// ==== Bender.yml ====
package:
  name: spi_reg_slave

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spi_pkg.sv
      - hdl/reg_pkg.sv
      - hdl/spi_input_sync.sv
      - hdl/spi_byte_engine.sv
      - hdl/spi_cmd_decoder.sv
      - hdl/spi_reg_bank.sv
      - hdl/spi_reg_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/spi_reg_assertions.sv
      - test/tb_spi_reg_top.sv

// ==== hdl/reg_pkg.sv ====
/*
 * Register-bank side types: addresses, data, the decoded command,
 * the write descriptor and the command decoder FSM states.
 */
`include "spi_params.svh"

package reg_pkg;

	typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // bank address
	typedef logic [7:0] reg_data_t; // register content

	// fields taken from the first byte of a frame
	typedef struct packed {
		logic wr; // 1 = write frame, 0 = read frame
		reg_addr_t addr; // start address, bits 3:0 of the command
	} cmd_t;

	// one register write, also the shape of the external report
	typedef struct packed {
		logic en; // single-cycle strobe
		reg_addr_t addr;
		reg_data_t data;
	} reg_wr_t;

	typedef enum logic [1:0] {
		dec_wait_cmd, // next byte is a command
		dec_read_stream, // bytes clock out bank contents
		dec_write_stream // bytes from mosi go to the bank
	} dec_state_e;

endpackage

// ==== hdl/spi_byte_engine.sv ====
/*
 * Byte-level SPI slave engine. Counts sixteen sclk edges per byte, samples
 * mosi on the sampling edges, shifts miso on the others, then strobes
 * rx_valid and reloads the transmit shifter while cs stays low.
 */
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_byte_engine #(
	parameter logic CPOL = `SPI_CPOL, // sclk idle level
	parameter logic CPHA = `SPI_CPHA // 1: sample on the second edge
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input spi_pkg::spi_edges_t edges,
	input spi_pkg::byte_t tx_data, // next byte to send, taken in finish
	output logic miso,
	output spi_pkg::byte_t rx_data, // valid while rx_valid is high
	output logic rx_valid,
	output logic frame_start
);
	import spi_pkg::*;

	// in modes 1 and 2 the first edge of a byte is the trail strobe
	localparam logic SWAP = CPOL ^ CPHA;
	localparam edge_cnt_t LAST_CNT = edge_cnt_t'(16);

	eng_state_e state;
	edge_cnt_t edge_cnt; // edges taken in this byte
	byte_t rx_shift; // mosi collects here, msb first
	byte_t tx_shift; // msb drives miso
	logic first_edge;
	logic second_edge;
	logic edge_hit; // expected edge seen in sclk_wait
	logic sample_now;
	logic shift_now;

	always_comb begin
		first_edge = SWAP ? edges.trail_edge : edges.lead_edge;
		second_edge = SWAP ? edges.lead_edge : edges.trail_edge;
		edge_hit = (state == eng_sclk_wait) && (edge_cnt[0] ? second_edge : first_edge);
		sample_now = edge_hit && (edge_cnt[0] == CPHA); // even edges for cpha 0
		// cpha 1 leaves the very first edge alone, bit 7 is already out
		shift_now = edge_hit && (edge_cnt[0] != CPHA) && !(CPHA && edge_cnt == '0);
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= eng_idle;
		end else if (edges.cs) begin
			state <= eng_idle; // cs high ends or aborts the frame
		end else begin
			case (state)
				eng_idle: state <= eng_sclk_wait; // cs just went low
				eng_sclk_wait: begin
					if (edge_hit) begin
						state <= eng_sclk_edge;
					end
				end
				eng_sclk_edge: state <= (edge_cnt == LAST_CNT) ? eng_last_half : eng_sclk_wait;
				eng_last_half: state <= eng_ack; // latch rx byte
				eng_ack: state <= eng_finish; // rx_valid cycle
				eng_finish: state <= eng_sclk_wait; // tx reload, next byte
				default: state <= eng_idle;
			endcase
		end
	end

	// edge counter, restarts every byte
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			edge_cnt <= '0;
		end else if (state == eng_idle || state == eng_finish) begin
			edge_cnt <= '0;
		end else if (edge_hit) begin
			edge_cnt <= edge_cnt + 1'b1;
		end
	end

	// transmit shifter
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			tx_shift <= '0;
		end else if (state == eng_idle) begin
			tx_shift <= '0; // command byte always answers 0x00
		end else if (state == eng_finish) begin
			tx_shift <= tx_data;
		end else if (shift_now) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
	end

	// receive shifter, partial byte dropped when cs rises
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || edges.cs_rise) begin
			rx_shift <= '0;
		end else if (sample_now) begin
			rx_shift <= {rx_shift[6:0], edges.mosi};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == eng_last_half) begin
			rx_data <= rx_shift; // held until the next byte completes
		end
	end

	assign miso = tx_shift[7];
	assign rx_valid = (state == eng_ack);
	assign frame_start = edges.cs_fall;

endmodule

// ==== hdl/spi_cmd_decoder.sv ====
/*
 * Command decoder. The first byte of each frame picks read or write and
 * the start address; every later byte steps the address, wrapping 15 to 0.
 * Writes leave as a combinational strobe in the rx_valid cycle.
 */
`timescale 1ns/100ps

module spi_cmd_decoder (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic frame_start, // cs fell
	input spi_pkg::byte_t rx_data,
	input logic rx_valid,
	output reg_pkg::reg_addr_t rd_addr, // address of the next byte to send
	output reg_pkg::reg_wr_t wr
);
	import reg_pkg::*;

	dec_state_e state;
	cmd_t cmd; // fields of rx_data seen as a command
	reg_addr_t addr; // current access address

	always_comb begin
		cmd.wr = rx_data[7]; // bits 6:4 ignored
		cmd.addr = rx_data[3:0];
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= dec_wait_cmd;
			addr <= '0;
		end else if (frame_start) begin
			state <= dec_wait_cmd; // every frame begins with a command
			addr <= '0;
		end else if (rx_valid) begin
			case (state)
				dec_wait_cmd: begin
					state <= cmd.wr ? dec_write_stream : dec_read_stream;
					addr <= cmd.addr;
				end
				dec_read_stream: addr <= addr + 1'b1; // next register goes out next
				dec_write_stream: addr <= addr + 1'b1; // after this byte lands
				default: state <= dec_wait_cmd;
			endcase
		end
	end

	// one write per data byte in a write frame
	always_comb begin
		wr.en = rx_valid && (state == dec_write_stream);
		wr.addr = addr;
		wr.data = rx_data;
	end

	assign rd_addr = addr; // updated the cycle after rx_valid

endmodule

// ==== hdl/spi_input_sync.sv ====
/*
 * Brings cs, sclk and mosi into the sys_clk domain and turns level changes
 * into one-cycle strobes. lead/trail follow the phase setting of the build.
 */
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_input_sync #(
	parameter logic CPHA = `SPI_CPHA // selects which sclk edge is the lead one
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input spi_pkg::spi_pins_t pins, // straight from the pads
	output spi_pkg::spi_edges_t edges // registered levels and strobes
);
	import spi_pkg::*;

	localparam int STAGES = `SPI_SYNC_STAGES;
	localparam spi_pins_t PINS_IDLE = '{cs: 1'b1, sclk: 1'b0, mosi: 1'b0};

	spi_pins_t sync_q [STAGES]; // metastability chain
	spi_pins_t last_q; // previous value of the final stage
	spi_pins_t cur; // final stage, safe to use
	logic sclk_rise;
	logic sclk_fall;

	always_comb begin
		cur = sync_q[STAGES-1];
		sclk_rise = cur.sclk & ~last_q.sclk;
		sclk_fall = ~cur.sclk & last_q.sclk;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				sync_q[i] <= PINS_IDLE; // cs held inactive
			end
			last_q <= PINS_IDLE;
			edges <= '{cs: 1'b1, default: 1'b0};
		end else begin
			sync_q[0] <= pins;
			for (int i = 1; i < STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			last_q <= cur;
			edges.cs <= cur.cs;
			edges.cs_fall <= last_q.cs & ~cur.cs;
			edges.cs_rise <= ~last_q.cs & cur.cs;
			edges.lead_edge <= CPHA ? sclk_fall : sclk_rise; // first edge per phase
			edges.trail_edge <= CPHA ? sclk_rise : sclk_fall;
			edges.mosi <= cur.mosi; // same delay as the strobes
		end
	end

endmodule

// ==== hdl/spi_params.svh ====
/*
 * Build-time constants for the SPI register slave.
 * Include wherever a mode default, sync depth or bank size is needed.
 */
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// spi mode, 3 by default
`define SPI_CPOL 1'b1 // sclk idles high
`define SPI_CPHA 1'b1 // sample on second edge

`define SPI_SYNC_STAGES 2 // flops per pin before edge detect

// register bank geometry
`define REG_ADDR_W 4
`define REG_DEPTH 16
`define REG_STATUS_ADDR 15 // read-only, live status byte

`endif

// ==== hdl/spi_pkg.sv ====
/*
 * Wire-level SPI types shared by the input synchronizer and the byte engine.
 * Import inside module bodies, use scoped names in port lists.
 */
package spi_pkg;

	typedef logic [7:0] byte_t; // one spi data byte
	typedef logic [4:0] edge_cnt_t; // sclk edges seen in current byte, 0..16

	// raw pins from the master
	typedef struct packed {
		logic cs; // active low frame select
		logic sclk;
		logic mosi;
	} spi_pins_t;

	// synchronized levels and single-cycle strobes
	typedef struct packed {
		logic cs; // synced cs level
		logic cs_fall; // frame opens
		logic cs_rise; // frame closes or aborts
		logic lead_edge; // first sclk edge of the phase
		logic trail_edge; // second sclk edge of the phase
		logic mosi; // synced mosi, aligned with the strobes
	} spi_edges_t;

	typedef enum logic [2:0] {
		eng_idle,
		eng_sclk_wait,
		eng_sclk_edge,
		eng_last_half,
		eng_ack,
		eng_finish
	} eng_state_e;

endpackage

// ==== hdl/spi_reg_bank.sv ====
/*
 * Sixteen-entry register map. 0..14 are writable storage cleared at reset,
 * the top address reads status_in live and drops writes. Accepted writes
 * are reported one cycle later on reg_wr.
 */
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_reg_bank (
	input logic sys_clk,
	input logic sys_rst_n,
	input reg_pkg::reg_wr_t wr,
	input reg_pkg::reg_addr_t rd_addr,
	input spi_pkg::byte_t status_in, // live status, not stored
	output reg_pkg::reg_data_t rd_data,
	output reg_pkg::reg_wr_t reg_wr // external write report
);
	import reg_pkg::*;

	localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`REG_STATUS_ADDR);

	reg_data_t regs [`REG_DEPTH-1]; // status slot has no storage
	logic wr_ok; // write to a real register

	assign wr_ok = wr.en && (wr.addr != STATUS_ADDR);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `REG_DEPTH-1; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// registered copy of every accepted write
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			reg_wr.en <= 1'b0;
		end else begin
			reg_wr.en <= wr_ok; // status writes never show up
			reg_wr.addr <= wr.addr;
			reg_wr.data <= wr.data;
		end
	end

	// combinational read, status mapped on top
	assign rd_data = (rd_addr == STATUS_ADDR) ? status_in : regs[rd_addr];

endmodule

// ==== hdl/spi_reg_top.sv ====
/*
 * SPI register slave top. Pins go through the synchronizer into the byte
 * engine; the decoder turns bytes into bank accesses and the bank feeds
 * the next transmit byte back to the engine.
 */
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_reg_top (
	input logic sys_clk,
	input logic sys_rst_n,
	input spi_pkg::spi_pins_t pins, // cs, sclk, mosi from the master
	input spi_pkg::byte_t status_in, // shows up at the status address
	output logic miso,
	output reg_pkg::reg_wr_t reg_wr // one pulse per committed write
);
	import spi_pkg::*;
	import reg_pkg::*;

	spi_edges_t edges;
	byte_t rx_data;
	logic rx_valid;
	logic frame_start;
	reg_addr_t rd_addr;
	reg_wr_t wr;
	reg_data_t rd_data; // doubles as the engine's tx byte

	spi_input_sync #(
		.CPHA(`SPI_CPHA)
	) i_input_sync (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.pins(pins),
		.edges(edges)
	);

	spi_byte_engine #(
		.CPOL(`SPI_CPOL),
		.CPHA(`SPI_CPHA)
	) i_byte_engine (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.edges(edges),
		.tx_data(rd_data),
		.miso(miso),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.frame_start(frame_start)
	);

	spi_cmd_decoder i_cmd_decoder (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.frame_start(frame_start),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rd_addr(rd_addr),
		.wr(wr)
	);

	spi_reg_bank i_reg_bank (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.wr(wr),
		.rd_addr(rd_addr),
		.status_in(status_in),
		.rd_data(rd_data),
		.reg_wr(reg_wr)
	);

endmodule

// ==== test/spi_reg_assertions.sv ====
/*
 * Concurrent checks on the SPI register slave, bound into the top level.
 * Covers the rx strobe width, writes outside a frame and reset outputs.
 */
`timescale 1ns/100ps

module spi_reg_assertions (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic cs, // synced cs level inside the slave
	input logic rx_valid,
	input logic reg_wr_en,
	input logic miso
);
	logic rst_held = 1'b0; // reset already applied on an earlier edge

	always @(posedge sys_clk) begin
		rst_held <= !sys_rst_n;
	end

	// one cycle per received byte
	rx_valid_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid stayed high for two cycles");

	// report trails rx_valid by a cycle, cs was low one cycle before that
	wr_in_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(reg_wr_en) |-> !$past(cs, 2))
		else $error("reg_wr pulse outside a frame");

	reset_quiet: assert property (@(posedge sys_clk)
		rst_held && !sys_rst_n |-> !reg_wr_en && !miso)
		else $error("reg_wr or miso high during reset");

endmodule

bind spi_reg_top spi_reg_assertions i_spi_reg_assertions (
	.sys_clk(sys_clk),
	.sys_rst_n(sys_rst_n),
	.cs(edges.cs),
	.rx_valid(rx_valid),
	.reg_wr_en(reg_wr.en),
	.miso(miso)
);

// ==== test/tb_spi_reg_top.sv ====
/*
 * Directed testbench for the SPI register slave. A mode 3 master task drives
 * frames, a monitor collects reg_wr pulses and a model tracks the bank.
 */
`timescale 1ns/100ps
`include "spi_params.svh"

module tb_spi_reg_top;
	import spi_pkg::*;
	import reg_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int HALF = 4; // sclk half period, sys_clk cycles
	localparam int GAP = 8; // between bytes, covers the tx reload
	localparam int CS_LEAD = 4; // cs low to first sclk edge
	localparam int CS_IDLE = 8; // cs high after a frame
	localparam int BYTE_CYC = 16 * HALF + GAP;
	localparam int N_FRAMES = 16; // all tests together
	localparam int N_BYTES = 50;
	localparam int RUN_CYC = 12 + N_FRAMES * (CS_LEAD + CS_IDLE) + N_BYTES * BYTE_CYC;

	logic sys_clk = 1'b0;
	logic sys_rst_n;
	spi_pins_t pins;
	byte_t status_in;
	logic miso;
	reg_wr_t reg_wr;

	reg_data_t model [`REG_DEPTH]; // expected bank contents
	reg_wr_t wr_seen [$]; // pulses caught by the monitor
	reg_wr_t wr_exp [$];
	byte_t tx_q [$]; // bytes of the next frame, command first
	byte_t rx_q [$]; // miso bytes returned
	int err_cnt = 0;
	int chk_cnt = 0;

	spi_reg_top i_spi_reg_top (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.pins(pins),
		.status_in(status_in),
		.miso(miso),
		.reg_wr(reg_wr)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	always @(negedge sys_clk) begin
		if (sys_rst_n && reg_wr.en) begin
			wr_seen.push_back(reg_wr); // mid-cycle, pulse is stable
		end
	end

	task automatic tick(input int n); // n rising edges, then the drive offset
		repeat (n) @(posedge sys_clk);
		#2;
	endtask

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		chk_cnt++;
		assert (act === exp) else begin
			err_cnt++;
			$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic xfer_byte(input byte_t tx, input int n_bits, output byte_t rx);
		rx = '0;
		for (int i = 7; i > 7 - n_bits; i--) begin
			pins.sclk = 1'b0; // shifting edge, mosi moves with it
			pins.mosi = tx[i];
			tick(HALF);
			pins.sclk = 1'b1; // sampling edge
			tick(HALF);
			rx[i] = miso; // late in the high phase, slave shift long done
		end
	endtask

	// last_bits below 8 cuts the final byte short and aborts the frame
	task automatic run_frame(input string name, input int last_bits);
		byte_t rx;
		rx_q.delete();
		wr_seen.delete();
		pins.cs = 1'b0;
		tick(CS_LEAD);
		foreach (tx_q[i]) begin
			if (i == tx_q.size() - 1 && last_bits < 8) begin
				xfer_byte(tx_q[i], last_bits, rx);
			end else begin
				xfer_byte(tx_q[i], 8, rx);
				tick(GAP);
			end
			rx_q.push_back(rx);
		end
		pins.cs = 1'b1;
		tick(CS_IDLE);
		check_val(name, 8'h00, rx_q[0]); // slave answers 0x00 to every command
	endtask

	task automatic check_writes(input string name); // entries shown as addr then data
		check_val(name, wr_exp.size(), wr_seen.size());
		foreach (wr_exp[i]) begin
			if (i < wr_seen.size()) begin
				check_val(name, {wr_exp[i].addr, wr_exp[i].data},
					{wr_seen[i].addr, wr_seen[i].data});
			end
		end
		wr_exp.delete();
	endtask

	task automatic write_frame(input string name, input reg_addr_t start, input int n);
		reg_addr_t a;
		a = start;
		tx_q.delete();
		tx_q.push_back({1'b1, 3'($urandom), start}); // bits 6:4 don't care
		for (int i = 0; i < n; i++) begin
			tx_q.push_back(8'($urandom));
			if (a != `REG_STATUS_ADDR) begin
				model[a] = tx_q[i + 1];
				wr_exp.push_back('{en: 1'b1, addr: a, data: tx_q[i + 1]});
			end
			a++; // 15 wraps to 0
		end
		run_frame(name, 8);
		check_writes(name);
	endtask

	task automatic read_frame(input string name, input reg_addr_t start, input int n);
		reg_addr_t a;
		a = start;
		tx_q.delete();
		tx_q.push_back({1'b0, 3'($urandom), start});
		for (int i = 0; i < n; i++) begin
			tx_q.push_back(8'($urandom)); // mosi ignored in a read
		end
		run_frame(name, 8);
		for (int i = 1; i <= n; i++) begin
			check_val(name, (a == `REG_STATUS_ADDR) ? status_in : model[a], rx_q[i]);
			a++;
		end
		check_writes(name); // reads never report writes
	endtask

	task automatic reset_values();
		read_frame("reset_values", 0, 15);
	endtask

	task automatic single_write();
		reg_addr_t a;
		a = reg_addr_t'($urandom_range(14));
		write_frame("single_write", a, 1);
		read_frame("single_write", a, 1);
	endtask

	task automatic burst_wrap();
		write_frame("burst_wrap", 13, 4); // 13, 14, status, 0
		read_frame("burst_wrap", 12, 6);
	endtask

	task automatic status_readback();
		repeat (3) begin
			status_in = 8'($urandom);
			read_frame("status_readback", `REG_STATUS_ADDR, 1);
		end
	endtask

	task automatic aborted_frame();
		reg_addr_t a;
		a = reg_addr_t'($urandom_range(14));
		tx_q.delete();
		tx_q.push_back({4'h8, a});
		tx_q.push_back(8'($urandom));
		run_frame("aborted_frame", 4); // cs rises after four sclk cycles of data
		check_writes("aborted_frame");
		read_frame("aborted_frame", a, 1); // old value kept
		write_frame("aborted_frame", a, 1);
		read_frame("aborted_frame", a, 1);
	endtask

	task automatic command_response();
		repeat (2) begin
			write_frame("command_response", 4'($urandom), 0);
			read_frame("command_response", 4'($urandom), 0);
		end
	endtask

	initial begin
		void'($urandom(90));
		sys_rst_n = 1'b0;
		pins = '{cs: 1'b1, sclk: 1'b1, mosi: 1'b0}; // mode 3 idle
		status_in = '0;
		foreach (model[i]) begin
			model[i] = '0;
		end
		tick(8);
		sys_rst_n = 1'b1;
		tick(4);
		reset_values();
		single_write();
		burst_wrap();
		status_readback();
		aborted_frame();
		command_response();
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// 1.5 times the expected run length
	initial begin
		#(RUN_CYC * CLK_PERIOD * 3 / 2);
		$display("watchdog expired, tests did not finish, errors so far: %0d", err_cnt);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/spi_pkg.sv
hdl/reg_pkg.sv
hdl/spi_input_sync.sv
hdl/spi_byte_engine.sv
hdl/spi_cmd_decoder.sv
hdl/spi_reg_bank.sv
hdl/spi_reg_top.sv
test/spi_reg_assertions.sv
test/tb_spi_reg_top.sv
